// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int data_width = 32;

  // opcode values not listed here behave as a nop
  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_sll  = 6'd7,
    op_srl  = 6'd8,
    op_addi = 6'd9,
    op_andi = 6'd10,
    op_ori  = 6'd11
  } opcode_e;

  // shifts move operand_b (rt) by shamt
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl
  } alu_op_e;

  // r-form layout, i-form words reuse the low 16 bits as immediate
  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct_unused;
  } inst_t;

  // imm16 is the i-form immediate, made of {rd, shamt, funct_unused}
  function automatic logic [15:0] imm16(inst_t inst);
    return {inst.rd, inst.shamt, inst.funct_unused};
  endfunction

  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] operand_b;
    logic [4:0]            shamt;
    logic [4:0]            dest;
    logic                  write;
  } exec_req_t;

  typedef struct packed {
    logic                  valid;
    logic [4:0]            dest;
    logic [data_width-1:0] value;
    logic                  write;
  } wb_t;

endpackage

`default_nettype wire

// File: hdl/apb_pkg.sv
`default_nettype none

package apb_pkg;

  // requester side of the bus, the slave drives prdata/pready/pslverr
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  // write-only, each write issues one instruction
  localparam logic [11:0] addr_issue = 12'h000;

  // register n lives at base + 4*n
  localparam logic [11:0] addr_reg_base = 12'h100;
  localparam logic [11:0] addr_reg_last = addr_reg_base + 12'd124;

endpackage

`default_nettype wire

// File: hdl/apb_issue_port.sv
`default_nettype none

module apb_issue_port #(
  parameter int num_regs = 32
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire apb_pkg::apb_req_t apb,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   issue,
  output isa_pkg::inst_t         issue_inst,
  output logic [4:0]             rd_addr,
  input  wire logic [31:0]       rd_data,
  input  wire logic [2:0]        stage_valid
);

  localparam int reg_aw = $clog2(num_regs);

  logic        setup_phase;
  logic        access_phase;
  logic [11:0] reg_offset;
  logic        reg_hit;
  logic        issue_hit;
  logic        read_hit;
  logic        busy_next;
  logic        pending;
  logic        pready_d;
  logic        pslverr_d;

  assign setup_phase  = apb.psel && !apb.penable;
  assign access_phase = apb.psel && apb.penable;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign reg_offset = apb.paddr - apb_pkg::addr_reg_base;

  // word aligned and below num_regs, so a 16 entry file leaves a hole
  assign reg_hit = (apb.paddr >= apb_pkg::addr_reg_base) &&
                   (apb.paddr <= apb_pkg::addr_reg_last) &&
                   (reg_offset[1:0] == 2'b00) &&
                   (int'(reg_offset[11:2]) < num_regs);

  assign issue_hit = apb.pwrite && (apb.paddr == apb_pkg::addr_issue);
  assign read_hit  = !apb.pwrite && reg_hit;
  assign rd_addr   = 5'(reg_offset[reg_aw+1:2]);

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // decode/execute entries are still in flight next cycle,
  // a result stage entry reaches the register file at this edge
  assign busy_next = stage_valid[0] || stage_valid[1];

  // transfer still waiting for its completing cycle
  assign pending = setup_phase || (access_phase && !pready);

  always_comb begin
    pready_d  = 1'b0;
    pslverr_d = 1'b0;
    if (pending) begin
      pready_d  = read_hit ? !busy_next : 1'b1;
      pslverr_d = !(issue_hit || read_hit);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= pready_d;
      pslverr <= pslverr_d;
    end
  end

  // one strobe in the completing access cycle
  assign issue      = access_phase && pready && issue_hit;
  assign issue_inst = isa_pkg::inst_t'(apb.pwdata);
  assign prdata     = (access_phase && pready && read_hit) ? rd_data : 32'd0;

  a_pready_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) pready |-> access_phase
  );

  // a register read only completes on a drained pipe
  a_read_on_idle_pipe: assert property (
    @(posedge clk) disable iff (!rst_n)
    (access_phase && pready && read_hit) |-> (stage_valid == 3'b000)
  );

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`default_nettype none

module decode_stage (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             issue,
  input  wire isa_pkg::inst_t                   issue_inst,
  output logic [4:0]                            rs_addr,
  output logic [4:0]                            rt_addr,
  input  wire logic [isa_pkg::data_width-1:0]   rs_data,
  input  wire logic [isa_pkg::data_width-1:0]   rt_data,
  input  wire isa_pkg::wb_t                     wb,
  output isa_pkg::exec_req_t                    req,
  output logic                                  valid
);

  logic                           valid_q;
  isa_pkg::inst_t                 inst_q;
  isa_pkg::alu_op_e               alu_op;
  logic                           use_imm;
  logic                           use_rd;
  logic                           writes;
  logic [4:0]                     dest;
  logic                           fwd_rs;
  logic                           fwd_rt;
  logic [isa_pkg::data_width-1:0] rs_val;
  logic [isa_pkg::data_width-1:0] rt_val;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      inst_q <= issue_inst;
    end
  end

  assign rs_addr = inst_q.rs;
  assign rt_addr = inst_q.rt;
  assign valid   = valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // control table
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op  = isa_pkg::alu_add;
    use_imm = 1'b0;
    use_rd  = 1'b1;
    writes  = 1'b1;
    case (inst_q.opcode)
      isa_pkg::op_add: alu_op = isa_pkg::alu_add;
      isa_pkg::op_sub: alu_op = isa_pkg::alu_sub;
      isa_pkg::op_and: alu_op = isa_pkg::alu_and;
      isa_pkg::op_or:  alu_op = isa_pkg::alu_or;
      isa_pkg::op_xor: alu_op = isa_pkg::alu_xor;
      isa_pkg::op_slt: alu_op = isa_pkg::alu_slt;
      isa_pkg::op_sll: alu_op = isa_pkg::alu_sll;
      isa_pkg::op_srl: alu_op = isa_pkg::alu_srl;
      // i-form, result goes to rt
      isa_pkg::op_addi,
      isa_pkg::op_andi,
      isa_pkg::op_ori: begin
        use_imm = 1'b1;
        use_rd  = 1'b0;
        if (inst_q.opcode == isa_pkg::op_andi) begin
          alu_op = isa_pkg::alu_and;
        end else if (inst_q.opcode == isa_pkg::op_ori) begin
          alu_op = isa_pkg::alu_or;
        end
      end
      // nop and unknown opcodes
      default: writes = 1'b0;
    endcase
  end

  assign dest = use_rd ? inst_q.rd : inst_q.rt;

  // bypass the entry being written back in this same cycle
  assign fwd_rs = wb.valid && wb.write && (wb.dest != 5'd0) && (wb.dest == inst_q.rs);
  assign fwd_rt = wb.valid && wb.write && (wb.dest != 5'd0) && (wb.dest == inst_q.rt);
  assign rs_val = fwd_rs ? wb.value : rs_data;
  assign rt_val = fwd_rt ? wb.value : rt_data;

  always_comb begin
    req.valid     = valid_q;
    req.alu_op    = alu_op;
    req.operand_a = rs_val;
    req.operand_b = use_imm ? {{(isa_pkg::data_width-16){1'b0}}, isa_pkg::imm16(inst_q)}
                            : rt_val;
    req.shamt     = inst_q.shamt;
    req.dest      = dest;
    req.write     = writes && (dest != 5'd0);
  end

  // the port must not issue faster than one per two cycles
  a_no_issue_overlap: assert property (
    @(posedge clk) disable iff (!rst_n) issue |-> !valid_q
  );

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`default_nettype none

module execute_stage (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire isa_pkg::exec_req_t req,
  output isa_pkg::wb_t            wb,
  output logic                    valid
);

  localparam int dw = isa_pkg::data_width;

  logic               valid_q;
  isa_pkg::exec_req_t req_q;
  logic [dw-1:0]      result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid;
    end
  end

  // payload only loads on a real request
  always_ff @(posedge clk) begin
    if (req.valid) begin
      req_q <= req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_q.alu_op)
      isa_pkg::alu_add: result = req_q.operand_a + req_q.operand_b;
      isa_pkg::alu_sub: result = req_q.operand_a - req_q.operand_b;
      isa_pkg::alu_and: result = req_q.operand_a & req_q.operand_b;
      isa_pkg::alu_or:  result = req_q.operand_a | req_q.operand_b;
      isa_pkg::alu_xor: result = req_q.operand_a ^ req_q.operand_b;
      // signed compare
      isa_pkg::alu_slt: begin
        result = {{(dw-1){1'b0}},
                  ($signed(req_q.operand_a) < $signed(req_q.operand_b))};
      end
      isa_pkg::alu_sll: result = req_q.operand_b << req_q.shamt;
      isa_pkg::alu_srl: result = req_q.operand_b >> req_q.shamt;
      default:          result = '0;
    endcase
  end

  always_comb begin
    wb.valid = valid_q;
    wb.dest  = req_q.dest;
    wb.value = result;
    wb.write = req_q.write;
  end

  assign valid = valid_q;

endmodule

`default_nettype wire

// File: hdl/result_stage.sv
`default_nettype none

module result_stage #(
  parameter int num_regs = 32
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire isa_pkg::wb_t                   wb_in,
  output isa_pkg::wb_t                        wb_out,
  input  wire logic [4:0]                     rs_addr,
  input  wire logic [4:0]                     rt_addr,
  input  wire logic [4:0]                     dbg_addr,
  output logic [isa_pkg::data_width-1:0]      rs_data,
  output logic [isa_pkg::data_width-1:0]      rt_data,
  output logic [isa_pkg::data_width-1:0]      dbg_data,
  output logic                                valid
);

  localparam int dw     = isa_pkg::data_width;
  localparam int reg_aw = $clog2(num_regs);

  logic          valid_q;
  isa_pkg::wb_t  wb_q;
  logic          wr_en;
  logic [dw-1:0] regs [num_regs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= wb_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_in.valid) begin
      wb_q <= wb_in;
    end
  end

  always_comb begin
    wb_out       = wb_q;
    wb_out.valid = valid_q;
  end

  assign valid = valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  // destinations past num_regs are dropped
  assign wr_en = valid_q && wb_q.write && (wb_q.dest != 5'd0) &&
                 (int'(wb_q.dest) < num_regs);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_q.dest[reg_aw-1:0]] <= wb_q.value;
    end
  end

  // r0 and unmapped entries read as zero
  function automatic logic [dw-1:0] read_reg(input logic [4:0] addr);
    if ((addr == 5'd0) || (int'(addr) >= num_regs)) begin
      return '0;
    end
    return regs[addr[reg_aw-1:0]];
  endfunction

  always_comb begin
    rs_data  = read_reg(rs_addr);
    rt_data  = read_reg(rt_addr);
    dbg_data = read_reg(dbg_addr);
  end

  // decode must already have cleared write for destination 0
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb_in.valid && wb_in.write) |-> (wb_in.dest != 5'd0)
  );

endmodule

`default_nettype wire

// File: hdl/risc_pipe.sv
`default_nettype none

module risc_pipe #(
  parameter int num_regs = 32
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire apb_pkg::apb_req_t apb,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);

  logic                           issue;
  isa_pkg::inst_t                 issue_inst;
  logic [4:0]                     rd_addr;
  logic [isa_pkg::data_width-1:0] rd_data;
  logic [4:0]                     rs_addr;
  logic [4:0]                     rt_addr;
  logic [isa_pkg::data_width-1:0] rs_data;
  logic [isa_pkg::data_width-1:0] rt_data;
  isa_pkg::exec_req_t             exec_req;
  isa_pkg::wb_t                   ex_wb;
  isa_pkg::wb_t                   res_wb;
  logic                           dec_valid;
  logic                           ex_valid;
  logic                           res_valid;

  // stage_valid is {result, execute, decode}
  apb_issue_port #(
    .num_regs(num_regs)
  ) port_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb        (apb),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .issue      (issue),
    .issue_inst (issue_inst),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .stage_valid({res_valid, ex_valid, dec_valid})
  );

  decode_stage decode_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .issue_inst (issue_inst),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .wb         (res_wb),
    .req        (exec_req),
    .valid      (dec_valid)
  );

  execute_stage execute_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (exec_req),
    .wb    (ex_wb),
    .valid (ex_valid)
  );

  result_stage #(
    .num_regs(num_regs)
  ) result_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_in    (ex_wb),
    .wb_out   (res_wb),
    .rs_addr  (rs_addr),
    .rt_addr  (rt_addr),
    .dbg_addr (rd_addr),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .dbg_data (rd_data),
    .valid    (res_valid)
  );

endmodule

`default_nettype wire

// File: tests/tb_apb_tasks.svh
////////////////////////////////////////////////////////////////////////////
// apb master
////////////////////////////////////////////////////////////////////////////

// setup now, access one cycle later, held until the slave gives pready
task automatic transfer(input logic write, input logic [11:0] addr,
                        input logic [31:0] wdata);
  apb.psel    = 1'b1;
  apb.penable = 1'b0;
  apb.pwrite  = write;
  apb.paddr   = addr;
  apb.pwdata  = wdata;
  @(posedge clk);
  #drive_delay;
  apb.penable = 1'b1;
  @(negedge clk);
  while (!pready) begin
    @(negedge clk);
  end
  @(posedge clk);
  #drive_delay;
  apb.psel    = 1'b0;
  apb.penable = 1'b0;
endtask

task automatic send_inst(input logic [31:0] word);
  exp_err = 1'b0;
  predict(word);
  transfer(1'b1, apb_pkg::addr_issue, word);
endtask

task automatic check_reg(input int n);
  exp_err   = 1'b0;
  exp_rdata = model_regs[n];
  transfer(1'b0, apb_pkg::addr_reg_base + 12'(4 * n), 32'd0);
endtask

task automatic check_all();
  for (int n = 0; n < 32; n++) begin
    check_reg(n);
  end
endtask

task automatic bad_access(input logic write, input logic [11:0] addr);
  exp_err = 1'b1;
  transfer(write, addr, $urandom);
endtask

////////////////////////////////////////////////////////////////////////////
// instruction words and model
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] encode_r(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
  return {op, rs, rt, rd, sh, 6'd0};
endfunction

function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [4:0] pick_reg();
  return 5'($urandom_range(31, 1));
endfunction

// r-form writes rd, i-form writes rt with a zero-extended immediate
task automatic predict(input logic [31:0] word);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] res;
  int          dest;
  a    = model_regs[word[25:21]];
  b    = model_regs[word[20:16]];
  imm  = {16'd0, word[15:0]};
  dest = word[15:11];
  res  = 32'd0;
  case (word[31:26])
    isa_pkg::op_add:  res = a + b;
    isa_pkg::op_sub:  res = a - b;
    isa_pkg::op_and:  res = a & b;
    isa_pkg::op_or:   res = a | b;
    isa_pkg::op_xor:  res = a ^ b;
    isa_pkg::op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    isa_pkg::op_sll:  res = b << word[10:6];
    isa_pkg::op_srl:  res = b >> word[10:6];
    isa_pkg::op_addi: begin
      res  = a + imm;
      dest = word[20:16];
    end
    isa_pkg::op_andi: begin
      res  = a & imm;
      dest = word[20:16];
    end
    isa_pkg::op_ori: begin
      res  = a | imm;
      dest = word[20:16];
    end
    default: dest = 0;
  endcase
  if (dest != 0) begin
    model_regs[dest] = res;
  end
endtask

// File: tests/risc_pipe_tb.sv
`default_nettype none

module risc_pipe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_half     = 50;
  localparam int drive_delay  = 1;
  localparam int reset_cycles = 10;
  // over twice the length of the full sequence
  localparam int max_cycles   = 3000;

  logic              clk;
  logic              rst_n;
  apb_pkg::apb_req_t apb;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;

  // expectation for the transfer now on the bus
  logic              exp_err;
  logic [31:0]       exp_rdata;
  logic [31:0]       model_regs [32];
  int                drain;
  int                cycles;
  logic              xfer_done;
  logic              issue_done;

  `include "tb_apb_tasks.svh"

  risc_pipe dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb     (apb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #clk_half clk = ~clk;

  assign xfer_done  = apb.psel && apb.penable && pready;
  assign issue_done = xfer_done && apb.pwrite && (apb.paddr == apb_pkg::addr_issue);

  // cycles until the newest instruction has reached the register file
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drain <= 0;
    end else if (issue_done) begin
      drain <= 3;
    end else if (drain != 0) begin
      drain <= drain - 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: sequence still running after %0d cycles", max_cycles);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  task automatic fail_value(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "check failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks on each transfer
  ////////////////////////////////////////////////////////////////////////////

  a_resp_flag: assert property (
    @(posedge clk) disable iff (!rst_n) xfer_done |-> (pslverr == exp_err)
  ) else fail_value($sformatf("pslverr %0b, expected %0b at 0x%03h",
                              $sampled(pslverr), $sampled(exp_err), $sampled(apb.paddr)));

  a_read_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    (xfer_done && !apb.pwrite && !exp_err) |-> (prdata == exp_rdata)
  ) else fail_value($sformatf("prdata %08h, expected %08h at 0x%03h",
                              $sampled(prdata), $sampled(exp_rdata), $sampled(apb.paddr)));

  // register reads wait for the pipe to drain
  a_read_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (apb.psel && apb.penable && !apb.pwrite && !exp_err && (drain != 0)) |-> !pready
  ) else fail_value($sformatf("read of 0x%03h completed with %0d cycles still in flight",
                              $sampled(apb.paddr), $sampled(drain)));

  a_idle_quiet: assert property (
    @(posedge clk) disable iff (!rst_n) !apb.psel |-> (!pready && !pslverr)
  ) else fail_value("pready or pslverr high on an idle bus");

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [4:0] d;
    logic [4:0] prev;
    logic [4:0] t;
    void'($urandom(32'ha630));
    clk       = 1'b0;
    rst_n     = 1'b0;
    apb       = '0;
    exp_err   = 1'b0;
    exp_rdata = 32'd0;
    cycles    = 0;
    for (int n = 0; n < 32; n++) begin
      model_regs[n] = 32'd0;
    end
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;

    // idle bus right after reset
    repeat (2) @(posedge clk);
    #drive_delay;

    check_all();

    // build full 32-bit values from two ori halves
    for (int i = 0; i < 12; i++) begin
      t = pick_reg();
      send_inst(encode_i(isa_pkg::op_ori, 5'd0, t, 16'($urandom)));
      send_inst(encode_r(isa_pkg::op_sll, 5'd0, t, t, 5'd16));
      send_inst(encode_i(isa_pkg::op_ori, t, t, 16'($urandom)));
      check_reg(t);
    end
    for (int i = 0; i < 8; i++) begin
      t = pick_reg();
      send_inst(encode_i((i % 2) ? isa_pkg::op_andi : isa_pkg::op_addi,
                         pick_reg(), t, 16'($urandom)));
      check_reg(t);
    end
    for (int op = isa_pkg::op_add; op <= isa_pkg::op_srl; op++) begin
      for (int k = 0; k < 4; k++) begin
        d = pick_reg();
        send_inst(encode_r(6'(op), pick_reg(), pick_reg(), d, 5'($urandom)));
        check_reg(d);
      end
    end

    // dependent chains at one issue per two cycles
    for (int c = 0; c < 6; c++) begin
      prev = pick_reg();
      d    = pick_reg();
      for (int k = 0; k < 8; k++) begin
        t = pick_reg();
        if (k % 3 == 2) begin
          send_inst(encode_i(isa_pkg::op_addi, d, t, 16'($urandom)));
        end else begin
          send_inst(encode_r(6'($urandom_range(8, 1)), d, prev, t, 5'($urandom)));
        end
        prev = d;
        d    = t;
      end
      check_all();
    end

    // writes to r0 and unknown opcodes
    for (int i = 0; i < 6; i++) begin
      send_inst(encode_r(6'($urandom_range(8, 1)), pick_reg(), pick_reg(), 5'd0,
                         5'($urandom)));
      send_inst(encode_i(isa_pkg::op_ori, pick_reg(), 5'd0, 16'($urandom)));
      send_inst(encode_r(6'($urandom_range(63, 12)), pick_reg(), pick_reg(), pick_reg(),
                         5'd1));
    end
    check_all();

    // read straight after an issue
    for (int i = 0; i < 8; i++) begin
      d = pick_reg();
      send_inst(encode_r(isa_pkg::op_add, pick_reg(), pick_reg(), d, 5'd0));
      check_reg(d);
    end

    bad_access(1'b0, apb_pkg::addr_issue);
    bad_access(1'b1, apb_pkg::addr_reg_base + 12'h008);
    bad_access(1'b1, apb_pkg::addr_reg_last);
    bad_access(1'b0, 12'h080);
    bad_access(1'b1, 12'hffc);
    bad_access(1'b0, apb_pkg::addr_reg_base + 12'h006);

    // error flag must drop once the bus goes idle
    repeat (2) @(posedge clk);
    #drive_delay;

    check_all();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: risc_pipe.f
+incdir+tests
hdl/isa_pkg.sv
hdl/apb_pkg.sv
hdl/apb_issue_port.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/risc_pipe.sv
tests/risc_pipe_tb.sv
